/* verilog/pongGeomPkg.sv */
package pongGeomPkg;

	//////////////////////////////
	// Coordinate and value types
	//////////////////////////////
	typedef logic [10:0] xCoordT;	// Horizontal pixel position
	typedef logic [9:0]  yCoordT;	// Vertical pixel position
	typedef logic [6:0]  speedT;	// Pixels moved per ball step
	typedef logic [3:0]  scoreT;	// One player score

	// Object sizes in pixels
	localparam int BALL_SIZE = 10;	// Square ball side
	localparam int PADDLE_W  = 10;
	localparam int PADDLE_H  = 50;

	// Fixed paddle columns
	localparam xCoordT LEFT_PADDLE_X  = 11'd40;
	localparam xCoordT RIGHT_PADDLE_X = 11'd600;

	// Serve spot near mid screen
	localparam xCoordT SERVE_X = 11'd315;
	localparam yCoordT SERVE_Y = 10'd235;

	// Just past the visible area where nothing is drawn
	localparam xCoordT OFFSCREEN_X = 11'd641;
	localparam yCoordT OFFSCREEN_Y = 10'd481;

	// Playfield limits
	localparam xCoordT RIGHT_GOAL_X  = 11'd630;	// Ball left edge at or past this scores
	localparam yCoordT BOTTOM_WALL_Y = 10'd470;	// Bounce back up from here

	// Pot scaling
	localparam yCoordT POT_DEADZONE = 10'd41;	// Bottom of pot travel ignored
	localparam yCoordT PADDLE_MAX_Y = 10'd430;	// Paddle top edge stays on screen

	localparam speedT START_SPEED = 7'd2;	// First serve of a match
	localparam speedT SERVE_SPEED = 7'd1;	// Serve after a goal

endpackage

/* verilog/pongCtrlPkg.sv */
package pongCtrlPkg;

	//////////////////////////////
	// Game FSM states
	//////////////////////////////
	typedef enum logic [3:0]
	{
		gsIdle,		// Everything parked
		gsMenu,		// Waiting on start button
		gsSetup,	// Scores cleared, first serve
		gsWait,		// One tick pause before play
		gsPlayers,	// Paddle refresh, four ticks
		gsBall,		// Ball moves one step
		gsCheck,	// Collision check then decision
		gsP1Scored,
		gsP2Scored
	} gameStateT;

	// Commands to the ball engine, acted on with tick
	typedef enum logic [2:0]
	{
		boHold,		// No change
		boPark,		// Move ball off screen
		boServeRight,
		boServeLeft,
		boStart,	// Match opening serve
		boStep,		// Advance by current speed
		boCheck		// Walls, paddles and goals
	} ballOpT;

endpackage

/* verilog/paddleMapper.sv */
`timescale 1ns/1ps

module paddleMapper
	import pongGeomPkg::*;
(
	input  logic       DIV_CLK,
	input  logic       reset,
	input  logic       updatePaddles,
	input  logic [7:0] pot1,
	input  logic [7:0] pot2,
	output yCoordT     leftPaddleY,
	output yCoordT     rightPaddleY
);

	// Pot value to paddle top edge
	function automatic yCoordT mapPot(input logic [7:0] pot);
		yCoordT scaled;
		yCoordT shifted;
		scaled = {1'b0, pot, 1'b0};	// Double to 0..510
		if (scaled < POT_DEADZONE)
			shifted = '0;	// Inside dead zone
		else
			shifted = scaled - POT_DEADZONE;
		if (shifted > PADDLE_MAX_Y)
			shifted = PADDLE_MAX_Y;	// Clamp at bottom of screen
		return shifted;
	endfunction

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			leftPaddleY  <= OFFSCREEN_Y;	// Parked until first refresh
			rightPaddleY <= OFFSCREEN_Y;
		end
		else if (updatePaddles)
		begin
			leftPaddleY  <= mapPot(pot1);	// Player 1 on the left
			rightPaddleY <= mapPot(pot2);
		end
	end

	// Any refresh leaves both paddles on screen
	property refreshInRange;
		@(posedge DIV_CLK) disable iff (reset)
		updatePaddles |=> (leftPaddleY <= PADDLE_MAX_Y) && (rightPaddleY <= PADDLE_MAX_Y);
	endproperty
	assert property (refreshInRange);

endmodule

/* verilog/ballEngine.sv */
`timescale 1ns/1ps

module ballEngine
	import pongGeomPkg::*;
	import pongCtrlPkg::*;
(
	input  logic   DIV_CLK,
	input  logic   reset,
	input  logic   tick,
	input  ballOpT ballOp,
	input  yCoordT leftPaddleY,
	input  yCoordT rightPaddleY,
	output xCoordT ballX,
	output yCoordT ballY,
	output logic   goalLeft,
	output logic   goalRight,
	output logic   paddleHit
);

	logic   dirX;	// 1 moves right
	logic   dirY;	// 1 moves down
	speedT  speedX;
	speedT  speedY;
	xCoordT ballRightX;
	yCoordT ballCenterY;
	logic   rightHit;
	logic   leftHit;

	// Point inside a paddle rectangle
	function automatic logic inRect(input xCoordT px, input yCoordT py,
		input xCoordT rx, input yCoordT ry);
		return (px >= rx) && (px < rx + xCoordT'(PADDLE_W)) &&
			(py >= ry) && (py < ry + yCoordT'(PADDLE_H));
	endfunction

	//////////////////////////////
	// Collision points
	//////////////////////////////
	assign ballRightX  = ballX + xCoordT'(BALL_SIZE);
	assign ballCenterY = ballY + yCoordT'(BALL_SIZE / 2);

	// Only count a hit while heading into the paddle
	assign rightHit = dirX && inRect(ballRightX, ballCenterY, RIGHT_PADDLE_X, rightPaddleY);
	assign leftHit  = !dirX && inRect(ballX, ballCenterY, LEFT_PADDLE_X, leftPaddleY);

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			ballX     <= OFFSCREEN_X;
			ballY     <= OFFSCREEN_Y;
			dirX      <= 1'b1;
			dirY      <= 1'b0;
			speedX    <= START_SPEED;
			speedY    <= START_SPEED;
			goalLeft  <= 1'b0;
			goalRight <= 1'b0;
			paddleHit <= 1'b0;
		end
		else if (tick)
		begin
			// Flags only live until the next tick
			goalLeft  <= 1'b0;
			goalRight <= 1'b0;
			paddleHit <= 1'b0;
			case (ballOp)
				boPark:
				begin
					ballX <= OFFSCREEN_X;
					ballY <= OFFSCREEN_Y;
				end
				boServeRight, boServeLeft:
				begin
					ballX  <= SERVE_X;
					ballY  <= SERVE_Y;
					dirX   <= (ballOp == boServeRight);
					dirY   <= 1'b0;	// Serve heads up
					speedX <= SERVE_SPEED;
					speedY <= SERVE_SPEED;
				end
				boStart:
				begin
					ballX  <= SERVE_X;
					ballY  <= SERVE_Y;
					dirX   <= 1'b1;
					dirY   <= 1'b0;
					speedX <= START_SPEED;
					speedY <= START_SPEED;
				end
				boStep:
				begin
					ballX <= dirX ? ballX + xCoordT'(speedX) : ballX - xCoordT'(speedX);
					ballY <= dirY ? ballY + yCoordT'(speedY) : ballY - yCoordT'(speedY);
				end
				boCheck:
				begin
					// Top wall with room for a speed bump this check
					if (ballY <= yCoordT'(speedY))
						dirY <= 1'b1;
					if (ballY >= BOTTOM_WALL_Y)
						dirY <= 1'b0;	// Bottom wall
					if (rightHit || leftHit)
					begin
						dirX      <= leftHit;	// Send back the other way
						speedX    <= speedX + 7'd1;
						speedY    <= speedY + 7'd1;
						paddleHit <= 1'b1;
					end
					goalLeft  <= (ballX < xCoordT'(speedX));	// Past player 1
					goalRight <= (ballX >= RIGHT_GOAL_X);	// Past player 2
				end
				default:
					;	// boHold
			endcase
		end
	end

	// One goal at a time
	assert property (@(posedge DIV_CLK) disable iff (reset) !(goalLeft && goalRight));

endmodule

/* verilog/gameControl.sv */
`timescale 1ns/1ps

module gameControl
	import pongGeomPkg::*;
	import pongCtrlPkg::*;
#(
	parameter int TICK_DIV  = 65536,
	parameter int WIN_SCORE = 11
)
(
	input  logic   DIV_CLK,
	input  logic   reset,
	input  logic   startBtn,
	input  logic   goalLeft,
	input  logic   goalRight,
	output logic   tick,
	output logic   updatePaddles,
	output ballOpT ballOp,
	output scoreT  p1Score,
	output scoreT  p2Score,
	output logic   gameActive
);

	localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [DIV_W-1:0] divCount;
	gameStateT        state;
	logic [1:0]       stepCount;	// Paddle ticks per ball step
	logic             checkDone;	// High once boCheck is sent and flags are valid

	//////////////////////////////
	// Tick divider
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			divCount <= '0;
			tick     <= 1'b0;
		end
		else if (divCount == DIV_W'(TICK_DIV - 1))
		begin
			divCount <= '0;
			tick     <= 1'b1;	// One clock wide
		end
		else
		begin
			divCount <= divCount + 1'b1;
			tick     <= 1'b0;
		end
	end

	//////////////////////////////
	// Game FSM with one move per tick
	//////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state     <= gsIdle;
			stepCount <= 2'd0;
			checkDone <= 1'b0;
			p1Score   <= '0;
			p2Score   <= '0;
		end
		else if (tick)
		begin
			case (state)
				gsIdle:
					state <= gsMenu;
				gsMenu:
					if (startBtn)
						state <= gsSetup;
				gsSetup:
				begin
					p1Score <= '0;	// New match
					p2Score <= '0;
					state   <= gsWait;
				end
				gsWait:
					state <= gsPlayers;
				gsPlayers:
				begin
					stepCount <= stepCount + 2'd1;	// Wraps back to 0
					if (stepCount == 2'd3)
						state <= gsBall;
				end
				gsBall:
					state <= gsCheck;
				gsCheck:
				begin
					checkDone <= !checkDone;
					if (checkDone)	// Second tick decides on flags
					begin
						if (goalRight)
							state <= gsP1Scored;
						else if (goalLeft)
							state <= gsP2Scored;
						else
							state <= gsPlayers;
					end
				end
				gsP1Scored:
				begin
					p1Score <= p1Score + 1'b1;
					state   <= (p1Score == scoreT'(WIN_SCORE)) ? gsIdle : gsWait;
				end
				gsP2Scored:
				begin
					p2Score <= p2Score + 1'b1;
					state   <= (p2Score == scoreT'(WIN_SCORE)) ? gsIdle : gsWait;
				end
				default:
					state <= gsIdle;
			endcase
		end
	end

	// Ball command for the current state used on tick
	always_comb
	begin
		case (state)
			gsIdle:     ballOp = boPark;
			gsSetup:    ballOp = boStart;
			gsBall:     ballOp = boStep;
			gsCheck:    ballOp = checkDone ? boHold : boCheck;
			gsP1Scored: ballOp = boServeRight;	// Serve toward player 2
			gsP2Scored: ballOp = boServeLeft;
			default:    ballOp = boHold;
		endcase
	end

	assign updatePaddles = tick && (state == gsPlayers);
	assign gameActive    = (state != gsIdle) && (state != gsMenu);

	// A step is always followed by a collision check
	property stepThenCheck;
		@(posedge DIV_CLK) disable iff (reset)
		(tick && ballOp == boStep) |-> (state == gsBall) ##1 (state == gsCheck);
	endproperty
	assert property (stepThenCheck);

endmodule

/* verilog/scoreDisplay.sv */
`timescale 1ns/1ps

module scoreDisplay
	import pongGeomPkg::*;
#(
	parameter int SCAN_BITS = 18
)
(
	input  logic       DIV_CLK,
	input  logic       reset,
	input  scoreT      p1Score,
	input  scoreT      p2Score,
	output logic [3:0] anodes,
	output logic [6:0] cathodes
);

	logic [SCAN_BITS-1:0] scanCount;
	logic [1:0]           digitSel;
	scoreT                digit;
	logic [6:0]           segments;

	assign digitSel = scanCount[SCAN_BITS-1 -: 2];	// Slow bits pick the digit

	// Right digit p2, third digit p1, rest blank zero
	always_comb
	begin
		case (digitSel)
			2'd0:    digit = p2Score;
			2'd2:    digit = p1Score;
			default: digit = '0;
		endcase
	end

	// Segment order a..g where low lights a segment
	always_comb
	begin
		case (digit)
			4'h0: segments = 7'b0000001;
			4'h1: segments = 7'b1001111;
			4'h2: segments = 7'b0010010;
			4'h3: segments = 7'b0000110;
			4'h4: segments = 7'b1001100;
			4'h5: segments = 7'b0100100;
			4'h6: segments = 7'b0100000;
			4'h7: segments = 7'b0001111;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0000100;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b1100000;	// Lowercase b
			4'hC: segments = 7'b0110001;
			4'hD: segments = 7'b1000010;	// Lowercase d
			4'hE: segments = 7'b0110000;
			default: segments = 7'b0111000;	// F
		endcase
	end

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scanCount <= '0;
			anodes    <= 4'b1110;	// Digit 0 first
			cathodes  <= 7'b0000001;	// Shows 0
		end
		else
		begin
			scanCount <= scanCount + 1'b1;	// Free running
			anodes    <= ~(4'b0001 << digitSel);
			cathodes  <= segments;
		end
	end

	assert property (@(posedge DIV_CLK) disable iff (reset) $onehot(~anodes));

endmodule

/* verilog/pongTop.sv */
`timescale 1ns/1ps

module pongTop #(
	parameter int TICK_DIV  = 65536,
	parameter int WIN_SCORE = 11,
	parameter int SCAN_BITS = 18
)
(
	input  logic               DIV_CLK,
	input  logic               reset,
	input  logic               startBtn,
	input  logic [7:0]         pot1,
	input  logic [7:0]         pot2,
	output pongGeomPkg::xCoordT ballX,
	output pongGeomPkg::yCoordT ballY,
	output pongGeomPkg::yCoordT leftPaddleY,
	output pongGeomPkg::yCoordT rightPaddleY,
	output pongGeomPkg::scoreT  p1Score,
	output pongGeomPkg::scoreT  p2Score,
	output logic               gameActive,
	output logic [3:0]         anodes,	// Active low
	output logic [6:0]         cathodes	// Active low
);

	//////////////////////////////
	// Control to ball and paddles
	//////////////////////////////
	logic                tick;
	logic                updatePaddles;
	pongCtrlPkg::ballOpT ballOp;
	logic                goalLeft;
	logic                goalRight;

	gameControl #(.TICK_DIV(TICK_DIV), .WIN_SCORE(WIN_SCORE)) control
	(
		.DIV_CLK(DIV_CLK), .reset(reset), .startBtn(startBtn),
		.goalLeft(goalLeft), .goalRight(goalRight),
		.tick(tick), .updatePaddles(updatePaddles), .ballOp(ballOp),
		.p1Score(p1Score), .p2Score(p2Score), .gameActive(gameActive)
	);

	paddleMapper paddles
	(
		.DIV_CLK(DIV_CLK), .reset(reset), .updatePaddles(updatePaddles),
		.pot1(pot1), .pot2(pot2),
		.leftPaddleY(leftPaddleY), .rightPaddleY(rightPaddleY)
	);

	ballEngine ball
	(
		.DIV_CLK(DIV_CLK), .reset(reset), .tick(tick), .ballOp(ballOp),
		.leftPaddleY(leftPaddleY), .rightPaddleY(rightPaddleY),
		.ballX(ballX), .ballY(ballY),
		.goalLeft(goalLeft), .goalRight(goalRight),
		.paddleHit()	// Hit flag not needed by the FSM
	);

	scoreDisplay #(.SCAN_BITS(SCAN_BITS)) display
	(
		.DIV_CLK(DIV_CLK), .reset(reset),
		.p1Score(p1Score), .p2Score(p2Score),
		.anodes(anodes), .cathodes(cathodes)
	);

endmodule

/* verif/pongModel.svh */
`ifndef PONG_MODEL_SVH
`define PONG_MODEL_SVH

//////////////////////////////
// Reference game numbers
//////////////////////////////
localparam int refServeX = 315;
localparam int refServeY = 235;
localparam int refParkX  = 641;	// Off the visible area
localparam int refParkY  = 481;
localparam int refWinEnd = 12;	// Score after the winning goal from 11

// Paddle top edge for one pot reading
function automatic int paddleRef(input int pot);
	int y;
	y = 2 * pot - 41;	// Double, then dead zone offset
	if (y < 0)
		y = 0;
	if (y > 430)
		y = 430;	// Bottom clamp
	return y;
endfunction

// Segments a..g where a low bit lights
function automatic logic [6:0] segRef(input int value);
	logic [6:0] seg;
	case (value)
		0:       seg = 7'b0000001;
		1:       seg = 7'b1001111;
		2:       seg = 7'b0010010;
		3:       seg = 7'b0000110;
		4:       seg = 7'b1001100;
		5:       seg = 7'b0100100;
		6:       seg = 7'b0100000;
		7:       seg = 7'b0001111;
		8:       seg = 7'b0000000;
		9:       seg = 7'b0000100;
		10:      seg = 7'b0001000;
		11:      seg = 7'b1100000;	// Lowercase b
		12:      seg = 7'b0110001;
		13:      seg = 7'b1000010;	// Lowercase d
		14:      seg = 7'b0110000;
		default: seg = 7'b0111000;
	endcase
	return seg;
endfunction

// Diagonal move within the speed bound
function automatic logic stepLegal(input int dx, input int dy, input int bound);
	int ax;
	int ay;
	ax = (dx < 0) ? -dx : dx;
	ay = (dy < 0) ? -dy : dy;
	return (ax == ay) && (ax >= 1) && (ax <= bound);
endfunction

`endif

/* verif/pongTb.sv */
`timescale 1ns/1ps

module pongTb;

	logic        DIV_CLK;
	logic        reset;
	logic        startBtn;
	logic [7:0]  pot1;
	logic [7:0]  pot2;
	logic [10:0] ballX;
	logic [9:0]  ballY;
	logic [9:0]  leftPaddleY;
	logic [9:0]  rightPaddleY;
	logic [3:0]  p1Score;
	logic [3:0]  p2Score;
	logic        gameActive;
	logic [3:0]  anodes;
	logic [6:0]  cathodes;

	int   errorCount = 0;
	int   checkCount = 0;
	int   lastX = 641;	// Model view of the previous sample
	int   lastY = 481;
	int   lastP1 = 0;
	int   lastP2 = 0;
	int   speedBound = 2;
	logic lastRight = 1'b0;	// Direction of the last move
	logic haveDir = 1'b0;
	int   potVals[8];
	int   waitCount;
	int   i;

	`include "pongModel.svh"

	pongTop #(.TICK_DIV(8), .WIN_SCORE(11), .SCAN_BITS(3)) uut
	(
		.DIV_CLK(DIV_CLK), .reset(reset), .startBtn(startBtn),
		.pot1(pot1), .pot2(pot2), .ballX(ballX), .ballY(ballY),
		.leftPaddleY(leftPaddleY), .rightPaddleY(rightPaddleY),
		.p1Score(p1Score), .p2Score(p2Score), .gameActive(gameActive),
		.anodes(anodes), .cathodes(cathodes)
	);

	always #4 DIV_CLK = ~DIV_CLK;	// 8 ns period

	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("ERROR: %s", what);
		errorCount++;
	endtask

	task automatic finishRun();
		$display("Closing report: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic nextCycle();
		@(posedge DIV_CLK);
		#1;	// Drive just after the edge
	endtask

	task automatic waitForActive(input logic level, input int limit, input string what,
		output logic reached);
		int count;
		count = 0;
		while (gameActive !== level && count < limit)
		begin
			nextCycle();
			count++;
		end
		reached = (gameActive === level);
		if (!reached)
			reportFailure({"timed out waiting for ", what});
	endtask

	//////////////////////////////
	// Output monitors
	//////////////////////////////
	task automatic checkDisplay();
		int lowCount;
		int lowIdx;
		int digit;
		lowCount = 0;
		lowIdx = 0;
		for (int k = 0; k < 4; k++)
		begin
			if (anodes[k] === 1'b0)
			begin
				lowCount++;
				lowIdx = k;
			end
		end
		digit = (lowIdx == 0) ? lastP2 : (lowIdx == 2) ? lastP1 : 0;	// Digits 1 and 3 blank zero
		if (lowCount != 1)
			reportFailure("anode outputs do not enable exactly one digit");
		else
			checkEq("cathodes", cathodes, segRef(digit));	// Latched from last cycle scores
	endtask

	task automatic checkBallAndScore();
		int   dx;
		int   dy;
		logic scored;
		logic wasParked;
		dx = int'(ballX) - lastX;
		dy = int'(ballY) - lastY;
		scored = (p1Score != lastP1) || (p2Score != lastP2);
		wasParked = (lastX == refParkX) && (lastY == refParkY);
		if (dx == 0 && dy == 0)
		begin
			if (scored)
				reportFailure("score changed while the ball stood still");
		end
		else if (ballX == refParkX && ballY == refParkY)
		begin
			if (scored)
				reportFailure("score changed as the ball was parked");
		end
		else if (ballX == refServeX && ballY == refServeY && (wasParked || scored))
		begin
			haveDir = 1'b0;
			if (wasParked)
			begin
				speedBound = 2;	// Match opening serve
				checkEq("p1Score", p1Score, 0);
				checkEq("p2Score", p2Score, 0);
			end
			else
			begin
				speedBound = 1;
				checkEq("p1Score", p1Score, lastRight ? lastP1 + 1 : lastP1);	// Right goal
				checkEq("p2Score", p2Score, lastRight ? lastP2 : lastP2 + 1);
			end
		end
		else
		begin
			if (haveDir && ((dx > 0) != lastRight))
				speedBound++;	// Paddle return
			if (!stepLegal(dx, dy, speedBound))
				reportFailure($sformatf("illegal ball move from (%0d,%0d) to (%0d,%0d), bound %0d",
					lastX, lastY, ballX, ballY, speedBound));
			if (scored)
				reportFailure("score changed during a ball move");
			lastRight = (dx > 0);
			haveDir = 1'b1;
		end
	endtask

	always @(negedge DIV_CLK)
	begin
		if (reset === 1'b0)
		begin
			checkDisplay();
			checkBallAndScore();
		end
		lastX = ballX;	// Held through reset too
		lastY = ballY;
		lastP1 = p1Score;
		lastP2 = p2Score;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic playMatches();
		logic reached;
		checkEq("gameActive", gameActive, 0);
		checkEq("p1Score", p1Score, 0);
		checkEq("p2Score", p2Score, 0);
		checkEq("ballX", ballX, refParkX);
		checkEq("ballY", ballY, refParkY);
		checkEq("leftPaddleY", leftPaddleY, refParkY);
		checkEq("rightPaddleY", rightPaddleY, refParkY);

		// Menu idles with start low
		waitCount = 50 + $urandom % 200;
		repeat (waitCount)
		begin
			nextCycle();
			if (gameActive)
				reportFailure("game became active without a start press");
		end
		startBtn = 1'b1;
		waitForActive(1'b1, 200, "the first game start", reached);
		if (!reached)
			return;
		startBtn = 1'b0;

		// Paddle rule with edge values first
		potVals[0] = 0;
		potVals[1] = 20;
		potVals[2] = 255;
		for (i = 3; i < 8; i++)
			potVals[i] = $urandom % 256;
		for (i = 0; i < 8; i++)
		begin
			pot1 = 8'(potVals[i]);
			pot2 = 8'(potVals[7 - i]);
			repeat (8 * 42) nextCycle();	// Over 40 ticks held
			if (!gameActive)
				reportFailure("game ended before a paddle check");
			checkEq("leftPaddleY", leftPaddleY, paddleRef(pot1));
			checkEq("rightPaddleY", rightPaddleY, paddleRef(pot2));
		end

		// Wandering paddles so goals happen
		waitCount = 0;
		while (gameActive && waitCount < 3000000)
		begin
			if (waitCount % 400 == 0)
			begin
				pot1 = 8'($urandom % 256);
				pot2 = 8'($urandom % 256);
			end
			nextCycle();
			waitCount++;
		end
		if (gameActive)
		begin
			reportFailure("timed out waiting for the match to end");
			return;
		end
		checkEq("winnerScore", (p1Score > p2Score) ? p1Score : p2Score, refWinEnd);

		waitCount = 0;
		while (!(ballX == refParkX && ballY == refParkY) && waitCount < 100)
		begin
			nextCycle();
			waitCount++;
		end
		if (!(ballX == refParkX && ballY == refParkY))
			reportFailure("ball was not parked after the match ended");

		// Rematch clears the scores
		startBtn = 1'b1;
		waitForActive(1'b1, 200, "the second game start", reached);
		if (!reached)
			return;
		startBtn = 1'b0;
		waitCount = 0;
		while ((p1Score != 0 || p2Score != 0) && waitCount < 100)
		begin
			nextCycle();
			waitCount++;
		end
		checkEq("p1Score", p1Score, 0);
		checkEq("p2Score", p2Score, 0);
		repeat (2000) nextCycle();
	endtask

	initial
	begin
		DIV_CLK = 1'b0;
		reset = 1'b1;
		startBtn = 1'b0;
		pot1 = 8'd0;
		pot2 = 8'd0;
		void'($urandom(32'ha45c));	// Fixed seed for the whole run
		repeat (16) @(posedge DIV_CLK);
		#1;
		reset = 1'b0;
		playMatches();
		finishRun();
	end

endmodule

/* list.f */
+incdir+verif
verilog/pongGeomPkg.sv
verilog/pongCtrlPkg.sv
verilog/paddleMapper.sv
verilog/ballEngine.sv
verilog/gameControl.sv
verilog/scoreDisplay.sv
verilog/pongTop.sv
verif/pongTb.sv

/* run.sh */
#!/bin/sh
# Build and run the Pong core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module pongTb -f list.f -o pongSim

./obj_dir/pongSim | tee sim.log

if grep -q "all tests passed" sim.log; then
	exit 0
else
	exit 1
fi
